// File: include/tmds_consts.svh
// TMDS encoding constants
`ifndef TMDS_CONSTS_SVH
`define TMDS_CONSTS_SVH

// --------------------
// Word geometry
// --------------------

// Encoded symbol width.
`define TMDS_WORD_BITS 10

// One color component per channel.
`define TMDS_COLOR_BITS 8

// Fast-clock cycles per pixel, two bits each.
`define TMDS_SERIAL_RATIO 5

// --------------------
// Control tokens
// --------------------

// Sent during blanking, selected by {c1, c0}.
`define TMDS_CTRL0 10'b1101010100
`define TMDS_CTRL1 10'b0010101011
`define TMDS_CTRL2 10'b0101010100
`define TMDS_CTRL3 10'b1010101011

`endif

// File: hw/videoPkg.sv
// Incoming video types
package videoPkg;

`include "tmds_consts.svh"

    // --------------------
    // Pixel data
    // --------------------

    // One pixel as it arrives from the video source.
    typedef struct packed {
        logic [`TMDS_COLOR_BITS-1:0] red;
        logic [`TMDS_COLOR_BITS-1:0] green;
        logic [`TMDS_COLOR_BITS-1:0] blue;
    } rgbPixel;

    // --------------------
    // Sync levels
    // --------------------

    // Packed as {vs, hs}, the order the blue channel sends them.
    typedef struct packed {
        logic vs;
        logic hs;
    } syncBits;

endpackage

// File: hw/tmdsPkg.sv
// TMDS link types
package tmdsPkg;

`include "tmds_consts.svh"

    // --------------------
    // Symbols
    // --------------------

    // One encoded 10-bit symbol.
    typedef logic [`TMDS_WORD_BITS-1:0] tmdsWord;

    // Control code carried during blanking.
    typedef enum logic [1:0] {
        C00 = 2'b00,
        C01 = 2'b01,
        C10 = 2'b10,
        C11 = 2'b11
    } ctrlCode;

    // Running disparity, ones minus zeros sent so far.
    typedef logic signed [4:0] disparity;

    // --------------------
    // Serializer phases
    // --------------------

    // PH0 follows the fast edge that lines up with the pixel clock.
    typedef enum logic [$clog2(`TMDS_SERIAL_RATIO)-1:0] {
        PH0,
        PH1,
        PH2,
        PH3,
        PH4
    } serPhase;

endpackage

// File: hw/tmdsWordIf.sv
// Encoded word bus
`timescale 1ns/1ns

interface tmdsWordIf;

    import tmdsPkg::*;

    // One encoded symbol per channel.
    tmdsWord wordRed;
    tmdsWord wordGreen;
    tmdsWord wordBlue;

    // High while the words hold valid data.
    logic wordStrobe;

    // Encoder side.
    modport producer (
        output wordRed,
        output wordGreen,
        output wordBlue,
        output wordStrobe
    );

    // Word buffer side.
    modport consumer (
        input wordRed,
        input wordGreen,
        input wordBlue,
        input wordStrobe
    );

endinterface

// File: hw/tmdsEncoder.sv
// Three-channel TMDS encoder
`timescale 1ns/1ns

`include "tmds_consts.svh"

module tmdsEncoder (
    input logic clkRGB,
    input logic rstN,
    input videoPkg::rgbPixel pixel,
    input logic blank,
    input videoPkg::syncBits sync,
    tmdsWordIf.producer words
);

    import tmdsPkg::*;

    // Channel 0 is blue, 1 is green, 2 is red.
    localparam int numChannels = 3;

    typedef struct packed {
        tmdsWord word;
        disparity cnt;
    } encResult;

    logic [`TMDS_COLOR_BITS-1:0] chanData [numChannels];
    ctrlCode chanCtrl [numChannels];
    encResult chanEnc [numChannels];
    disparity cntReg [numChannels];
    tmdsWord wordReg [numChannels];
    logic strobeReg;

    // --------------------
    // Encoding functions
    // --------------------

    function automatic tmdsWord tokenFor(input ctrlCode code);
        case (code)
            C01: return `TMDS_CTRL1;
            C10: return `TMDS_CTRL2;
            C11: return `TMDS_CTRL3;
            default: return `TMDS_CTRL0;
        endcase
    endfunction

    function automatic encResult encodeData(
        input logic [`TMDS_COLOR_BITS-1:0] d,
        input disparity cntIn
    );
        logic [8:0] qm;
        logic [3:0] onesD;
        logic [3:0] onesQ;
        logic useXnor;
        disparity diff;
        encResult r;
        onesD = '0;
        onesQ = '0;
        for (int i = 0; i < `TMDS_COLOR_BITS; i++)
        begin
            onesD = onesD + 4'(d[i]);
        end
        // Pick the stage that gives fewer transitions.
        useXnor = (onesD > 4'd4) || (onesD == 4'd4 && !d[0]);
        qm[0] = d[0];
        for (int i = 1; i < `TMDS_COLOR_BITS; i++)
        begin
            qm[i] = useXnor ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
        end
        qm[8] = ~useXnor;
        for (int i = 0; i < `TMDS_COLOR_BITS; i++)
        begin
            onesQ = onesQ + 4'(qm[i]);
        end
        // Ones minus zeros of the minimized byte.
        diff = disparity'(onesQ) - disparity'(4'd8 - onesQ);
        if (cntIn == 0 || diff == 0)
        begin
            r.word = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            r.cnt = qm[8] ? cntIn + diff : cntIn - diff;
        end
        else if ((cntIn > 0 && diff > 0) || (cntIn < 0 && diff < 0))
        begin
            // Invert to pull the count back toward zero.
            r.word = {1'b1, qm[8], ~qm[7:0]};
            r.cnt = cntIn + (qm[8] ? 5'sd2 : 5'sd0) - diff;
        end
        else
        begin
            r.word = {1'b0, qm[8], qm[7:0]};
            r.cnt = cntIn - (qm[8] ? 5'sd0 : 5'sd2) + diff;
        end
        return r;
    endfunction

    // --------------------
    // Channel mapping
    // --------------------

    assign chanData[0] = pixel.blue;
    assign chanData[1] = pixel.green;
    assign chanData[2] = pixel.red;

    // Sync rides on blue only.
    assign chanCtrl[0] = ctrlCode'({sync.vs, sync.hs});
    assign chanCtrl[1] = C00;
    assign chanCtrl[2] = C00;

    always_comb
    begin
        for (int ch = 0; ch < numChannels; ch++)
        begin
            if (blank)
            begin
                // Tokens are DC balanced, so the count starts over.
                chanEnc[ch].word = tokenFor(chanCtrl[ch]);
                chanEnc[ch].cnt = '0;
            end
            else
            begin
                chanEnc[ch] = encodeData(chanData[ch], cntReg[ch]);
            end
        end
    end

    // --------------------
    // Output registers
    // --------------------

    always_ff @(posedge clkRGB)
    begin
        if (!rstN)
        begin
            strobeReg <= 1'b0;
            for (int ch = 0; ch < numChannels; ch++)
            begin
                cntReg[ch] <= '0;
            end
        end
        else
        begin
            strobeReg <= 1'b1;
            for (int ch = 0; ch < numChannels; ch++)
            begin
                cntReg[ch] <= chanEnc[ch].cnt;
            end
        end
    end

    always_ff @(posedge clkRGB)
    begin
        for (int ch = 0; ch < numChannels; ch++)
        begin
            wordReg[ch] <= chanEnc[ch].word;
        end
    end

    assign words.wordBlue = wordReg[0];
    assign words.wordGreen = wordReg[1];
    assign words.wordRed = wordReg[2];
    assign words.wordStrobe = strobeReg;

endmodule

// File: hw/tmdsWordBuffer.sv
// Ping-pong word buffer
`timescale 1ns/1ns

module tmdsWordBuffer (
    input logic clkRGB,
    input logic clkTMDShalf,
    input logic rstN,
    tmdsWordIf.consumer words,
    input logic loadNow,
    output tmdsPkg::tmdsWord heldRed,
    output tmdsPkg::tmdsWord heldGreen,
    output tmdsPkg::tmdsWord heldBlue
);

    import tmdsPkg::*;

    tmdsWord slotRed [2];
    tmdsWord slotGreen [2];
    tmdsWord slotBlue [2];
    logic [1:0] slotValid;
    logic wrSel;
    logic rdSel;

    // --------------------
    // Pixel clock side
    // --------------------

    always_ff @(posedge clkRGB)
    begin
        if (!rstN)
        begin
            wrSel <= 1'b0;
            slotValid <= '0;
        end
        else if (words.wordStrobe)
        begin
            wrSel <= ~wrSel;
            slotValid[wrSel] <= 1'b1;
        end
    end

    always_ff @(posedge clkRGB)
    begin
        if (words.wordStrobe)
        begin
            slotRed[wrSel] <= words.wordRed;
            slotGreen[wrSel] <= words.wordGreen;
            slotBlue[wrSel] <= words.wordBlue;
        end
    end

    // --------------------
    // Fast clock side
    // --------------------

    // The serializer reads the slot filled one pixel earlier, then flips.
    always_ff @(posedge clkTMDShalf)
    begin
        if (!rstN)
        begin
            rdSel <= 1'b0;
        end
        else if (loadNow)
        begin
            rdSel <= ~rdSel;
        end
    end

    // Zeros until the slot has seen a word.
    assign heldRed = slotValid[rdSel] ? slotRed[rdSel] : '0;
    assign heldGreen = slotValid[rdSel] ? slotGreen[rdSel] : '0;
    assign heldBlue = slotValid[rdSel] ? slotBlue[rdSel] : '0;

endmodule

// File: hw/tmdsSerializer.sv
// Two-bit TMDS lane serializer
`timescale 1ns/1ns

`include "tmds_consts.svh"

module tmdsSerializer (
    input logic clkTMDShalf,
    input logic rstN,
    input tmdsPkg::tmdsWord heldRed,
    input tmdsPkg::tmdsWord heldGreen,
    input tmdsPkg::tmdsWord heldBlue,
    output logic loadNow,
    output logic [1:0] laneClk,
    output logic [1:0] laneD0,
    output logic [1:0] laneD1,
    output logic [1:0] laneD2
);

    import tmdsPkg::*;

    // Five ones then five zeros, LSB first.
    localparam tmdsWord clkPattern = 10'b0000011111;

    serPhase phase;
    serPhase phaseNext;
    tmdsWord shiftRed;
    tmdsWord shiftGreen;
    tmdsWord shiftBlue;
    tmdsWord shiftClk;

    function automatic tmdsWord shiftPair(input tmdsWord w);
        return {2'b00, w[`TMDS_WORD_BITS-1:2]};
    endfunction

    // --------------------
    // Phase FSM
    // --------------------

    always_comb
    begin
        case (phase)
            PH0: phaseNext = PH1;
            PH1: phaseNext = PH2;
            PH2: phaseNext = PH3;
            PH3: phaseNext = PH4;
            default: phaseNext = PH0;
        endcase
    end

    always_ff @(posedge clkTMDShalf)
    begin
        if (!rstN)
        begin
            phase <= PH0;
        end
        else
        begin
            phase <= phaseNext;
        end
    end

    // Last phase of the pixel, the load happens on the next edge.
    assign loadNow = (phase == PH4);

    // --------------------
    // Shift registers
    // --------------------

    always_ff @(posedge clkTMDShalf)
    begin
        if (!rstN)
        begin
            shiftRed <= '0;
            shiftGreen <= '0;
            shiftBlue <= '0;
            shiftClk <= '0;
        end
        else if (loadNow)
        begin
            shiftRed <= heldRed;
            shiftGreen <= heldGreen;
            shiftBlue <= heldBlue;
            shiftClk <= clkPattern;
        end
        else
        begin
            shiftRed <= shiftPair(shiftRed);
            shiftGreen <= shiftPair(shiftGreen);
            shiftBlue <= shiftPair(shiftBlue);
            shiftClk <= shiftPair(shiftClk);
        end
    end

    // Bit 0 goes out in the first half of the fast cycle.
    assign laneClk = shiftClk[1:0];
    assign laneD0 = shiftBlue[1:0];
    assign laneD1 = shiftGreen[1:0];
    assign laneD2 = shiftRed[1:0];

endmodule

// File: hw/rgbToTmds.sv
// RGB to TMDS transmitter
`timescale 1ns/1ns

module rgbToTmds (
    input logic clkRGB,
    input logic clkTMDShalf,
    input logic rstN,
    input logic [7:0] red,
    input logic [7:0] green,
    input logic [7:0] blue,
    input logic blk,
    input logic hs,
    input logic vs,
    output logic [1:0] laneClk,
    output logic [1:0] laneD0,
    output logic [1:0] laneD1,
    output logic [1:0] laneD2
);

    import videoPkg::*;
    import tmdsPkg::*;

    rgbPixel pixel;
    syncBits sync;
    tmdsWord heldRed;
    tmdsWord heldGreen;
    tmdsWord heldBlue;
    logic loadNow;

    tmdsWordIf wordBus ();

    assign pixel = '{red: red, green: green, blue: blue};
    assign sync = '{vs: vs, hs: hs};

    // --------------------
    // Pipeline
    // --------------------

    tmdsEncoder encoder0 (
        .clkRGB(clkRGB),
        .rstN  (rstN),
        .pixel (pixel),
        .blank (blk),
        .sync  (sync),
        .words (wordBus.producer)
    );

    tmdsWordBuffer buffer0 (
        .clkRGB     (clkRGB),
        .clkTMDShalf(clkTMDShalf),
        .rstN       (rstN),
        .words      (wordBus.consumer),
        .loadNow    (loadNow),
        .heldRed    (heldRed),
        .heldGreen  (heldGreen),
        .heldBlue   (heldBlue)
    );

    tmdsSerializer serializer0 (
        .clkTMDShalf(clkTMDShalf),
        .rstN       (rstN),
        .heldRed    (heldRed),
        .heldGreen  (heldGreen),
        .heldBlue   (heldBlue),
        .loadNow    (loadNow),
        .laneClk    (laneClk),
        .laneD0     (laneD0),
        .laneD1     (laneD1),
        .laneD2     (laneD2)
    );

endmodule

// File: testbench/tmds_sva.sv
// Serializer assertions
`timescale 1ns/1ns

module tmdsSva (
    input logic clkTMDShalf,
    input logic rstN,
    input logic loadNow,
    input logic [1:0] laneClk,
    input tmdsPkg::tmdsWord heldRed,
    input tmdsPkg::tmdsWord heldGreen,
    input tmdsPkg::tmdsWord heldBlue
);

    // One load every fifth fast cycle.
    loadEveryPixel: assert property (@(posedge clkTMDShalf) disable iff (!rstN)
        loadNow |=> !loadNow [*4] ##1 loadNow)
        else $error("loadNow does not repeat once per pixel period");

    // Clock lane sends 0000011111 LSB first after every load.
    clkLaneAfterLoad: assert property (@(posedge clkTMDShalf) disable iff (!rstN)
        loadNow |=> laneClk == 2'b11 ##1 laneClk == 2'b11 ##1 laneClk == 2'b01
            ##1 laneClk == 2'b00 ##1 laneClk == 2'b00)
        else $error("clock lane pattern broken after a load");

    // Held words only move on the load edge.
    heldStableInPixel: assert property (@(posedge clkTMDShalf) disable iff (!rstN)
        !loadNow |=> $stable({heldRed, heldGreen, heldBlue}))
        else $error("held words changed inside a pixel period");

endmodule

// File: testbench/tbRgbToTmds.sv
// RGB to TMDS testbench
`timescale 1ns/1ns

`include "tmds_consts.svh"

module tbRgbToTmds;

    import tmdsPkg::*;

    localparam time clkPeriod = 10;
    localparam int resetCycles = 3;
    localparam int syncLen = 3;
    localparam int randLen = 16;
    localparam int blankLen = 4;
    localparam int runLen = 10;
    localparam int lineLen = 20;
    localparam int numPixels = 4 * syncLen + randLen + 4 * blankLen + 3 * runLen + 2 * lineLen;
    localparam tmdsWord clkWordExp = 10'b0000011111;

    typedef struct {
        time sampledAt;
        tmdsWord wRed;
        tmdsWord wGreen;
        tmdsWord wBlue;
    } expTriple;

    logic clkRGB;
    logic clkTMDShalf;
    logic rstN;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic blk;
    logic hs;
    logic vs;
    logic [1:0] laneClk;
    logic [1:0] laneD0;
    logic [1:0] laneD1;
    logic [1:0] laneD2;

    expTriple expQ [$];
    int checkedWords = 0;

    rgbToTmds dut0 (
        .clkRGB     (clkRGB),
        .clkTMDShalf(clkTMDShalf),
        .rstN       (rstN),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .blk        (blk),
        .hs         (hs),
        .vs         (vs),
        .laneClk    (laneClk),
        .laneD0     (laneD0),
        .laneD1     (laneD1),
        .laneD2     (laneD2)
    );

    bind tmdsSerializer tmdsSva sva0 (
        .clkTMDShalf(clkTMDShalf),
        .rstN       (rstN),
        .loadNow    (loadNow),
        .laneClk    (laneClk),
        .heldRed    (heldRed),
        .heldGreen  (heldGreen),
        .heldBlue   (heldBlue)
    );

    // --------------------
    // Clocks and watchdog
    // --------------------

    initial
    begin
        clkRGB = 1'b0;
        forever #5 clkRGB = ~clkRGB;
    end

    // Five fast cycles per pixel, rising edges line up.
    initial
    begin
        clkTMDShalf = 1'b0;
        forever #1 clkTMDShalf = ~clkTMDShalf;
    end

    initial
    begin
        #((resetCycles + numPixels + 20) * clkPeriod);
        abortRun("Timeout: the lanes did not deliver every expected word in time.");
    end

    // --------------------
    // Reporting
    // --------------------

    task automatic abortRun(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic reportMismatch(input string msg);
        abortRun($sformatf("ERR %0t: %s", $time, msg));
    endtask

    task automatic compareWord(input tmdsWord got, input tmdsWord exp, input string what);
        if (got !== exp)
        begin
            reportMismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    task automatic compareClkPattern(input tmdsWord got);
        if (got !== clkWordExp)
        begin
            reportMismatch($sformatf("clock lane got %b expected %b", got, clkWordExp));
        end
    endtask

    // --------------------
    // Reference encoder
    // --------------------

    function automatic tmdsWord refToken(input logic [1:0] code);
        case (code)
            2'b01: return `TMDS_CTRL1;
            2'b10: return `TMDS_CTRL2;
            2'b11: return `TMDS_CTRL3;
            default: return `TMDS_CTRL0;
        endcase
    endfunction

    function automatic tmdsWord refEncode(input logic [7:0] d, input int cntIn, output int cntOut);
        logic [8:0] qm;
        logic xnorStage;
        int n1q;
        int n0q;
        tmdsWord result;
        xnorStage = ($countones(d) > 4) || ($countones(d) == 4 && d[0] == 1'b0);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++)
        begin
            qm[i] = xnorStage ? (qm[i-1] ~^ d[i]) : (qm[i-1] ^ d[i]);
        end
        qm[8] = !xnorStage;
        n1q = $countones(qm[7:0]);
        n0q = 8 - n1q;
        if (cntIn == 0 || n1q == n0q)
        begin
            result = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            cntOut = qm[8] ? cntIn + n1q - n0q : cntIn + n0q - n1q;
        end
        else if ((cntIn > 0 && n1q > n0q) || (cntIn < 0 && n0q > n1q))
        begin
            result = {1'b1, qm[8], ~qm[7:0]};
            cntOut = cntIn + 2 * int'(qm[8]) + n0q - n1q;
        end
        else
        begin
            result = {1'b0, qm[8], qm[7:0]};
            cntOut = cntIn - 2 * int'(!qm[8]) + n1q - n0q;
        end
        return result;
    endfunction

    // Expected triple for every pixel the DUT samples after reset.
    initial
    begin : referenceModel
        int cnt [3];
        int cntNext;
        expTriple e;
        cnt = '{0, 0, 0};
        @(posedge clkRGB);
        while (rstN !== 1'b1)
        begin
            @(posedge clkRGB);
        end
        repeat (numPixels)
        begin
            e.sampledAt = $time;
            if (blk)
            begin
                e.wBlue = refToken({vs, hs});
                e.wGreen = refToken(2'b00);
                e.wRed = refToken(2'b00);
                cnt = '{0, 0, 0};
            end
            else
            begin
                e.wBlue = refEncode(blue, cnt[0], cntNext);
                cnt[0] = cntNext;
                e.wGreen = refEncode(green, cnt[1], cntNext);
                cnt[1] = cntNext;
                e.wRed = refEncode(red, cnt[2], cntNext);
                cnt[2] = cntNext;
            end
            expQ.push_back(e);
            @(posedge clkRGB);
        end
    end

    // --------------------
    // Stimulus
    // --------------------

    function automatic logic [23:0] randomPixel();
        return 24'($urandom);
    endfunction

    task automatic drivePixel(input logic [23:0] rgb, input logic blank, input logic [1:0] vsHs);
        red <= rgb[23:16];
        green <= rgb[15:8];
        blue <= rgb[7:0];
        blk <= blank;
        vs <= vsHs[1];
        hs <= vsHs[0];
        @(posedge clkRGB);
    endtask

    // Colors keep changing so the tokens must ignore them.
    task automatic sendBlanking(input int n, input logic [1:0] vsHs);
        repeat (n)
        begin
            drivePixel(randomPixel(), 1'b1, vsHs);
        end
    endtask

    task automatic sendRun(input logic [23:0] rgb, input int n);
        repeat (n)
        begin
            drivePixel(rgb, 1'b0, 2'b00);
        end
    endtask

    initial
    begin : stimulus
        logic [23:0] lineB [lineLen];
        void'($urandom(57898));
        rstN <= 1'b0;
        red <= '0;
        green <= '0;
        blue <= '0;
        blk <= 1'b1;
        hs <= 1'b0;
        vs <= 1'b0;
        for (int i = 0; i < lineLen; i++)
        begin
            lineB[i] = randomPixel();
        end
        repeat (resetCycles) @(posedge clkRGB);
        rstN <= 1'b1;
        for (int s = 0; s < 4; s++)
        begin
            sendBlanking(syncLen, 2'(s));
        end
        repeat (randLen) drivePixel(randomPixel(), 1'b0, 2'b00);
        sendBlanking(blankLen, 2'b00);
        sendRun(24'h000000, runLen);
        sendRun(24'hFFFFFF, runLen);
        sendRun(24'hAAAAAA, runLen);
        sendBlanking(blankLen, 2'b01);
        // Same line twice, the words repeat once the count restarts.
        for (int i = 0; i < lineLen; i++)
        begin
            drivePixel(lineB[i], 1'b0, 2'b00);
        end
        sendBlanking(blankLen, 2'b10);
        for (int i = 0; i < lineLen; i++)
        begin
            drivePixel(lineB[i], 1'b0, 2'b00);
        end
        sendBlanking(blankLen, 2'b11);
    end

    // --------------------
    // Lane capture and compare
    // --------------------

    initial
    begin : compareLanes
        tmdsWord gotClk;
        tmdsWord gotRed;
        tmdsWord gotGreen;
        tmdsWord gotBlue;
        time windowStart;
        expTriple e;
        logic [1:0] prevClk;
        prevClk = 2'b00;
        @(negedge clkTMDShalf);
        // A pixel period starts where the clock lane leaves 00 for 11.
        while (prevClk !== 2'b00 || laneClk !== 2'b11)
        begin
            if ({laneD0, laneD1, laneD2} !== 6'b0)
            begin
                reportMismatch("data lanes active before the first pixel period");
            end
            prevClk = laneClk;
            @(negedge clkTMDShalf);
        end
        while (checkedWords < numPixels)
        begin
            windowStart = $time - 1;
            for (int i = 0; i < `TMDS_SERIAL_RATIO; i++)
            begin
                if (i > 0)
                begin
                    @(negedge clkTMDShalf);
                end
                gotClk[2*i +: 2] = laneClk;
                gotBlue[2*i +: 2] = laneD0;
                gotGreen[2*i +: 2] = laneD1;
                gotRed[2*i +: 2] = laneD2;
            end
            compareClkPattern(gotClk);
            if (expQ.size() > 0 && expQ[0].sampledAt == windowStart - 2 * clkPeriod)
            begin
                e = expQ.pop_front();
                compareWord(gotBlue, e.wBlue, "lane D0 (blue)");
                compareWord(gotGreen, e.wGreen, "lane D1 (green)");
                compareWord(gotRed, e.wRed, "lane D2 (red)");
                checkedWords++;
            end
            else if (checkedWords == 0 &&
                     (expQ.size() == 0 || expQ[0].sampledAt > windowStart - 2 * clkPeriod))
            begin
                compareWord(gotBlue, '0, "lane D0 before the first word");
                compareWord(gotGreen, '0, "lane D1 before the first word");
                compareWord(gotRed, '0, "lane D2 before the first word");
            end
            else
            begin
                reportMismatch("lane data out of step with the input stream");
            end
            @(negedge clkTMDShalf);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
hw/videoPkg.sv
hw/tmdsPkg.sv
hw/tmdsWordIf.sv
hw/tmdsEncoder.sv
hw/tmdsWordBuffer.sv
hw/tmdsSerializer.sv
hw/rgbToTmds.sv
testbench/tmds_sva.sv
testbench/tbRgbToTmds.sv

// File: Makefile
TOP := tbRgbToTmds

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -sv --top-module $(TOP) -f list.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
